//--- src/spi_pkg.sv
package spi_pkg;

   // serial link word size
   localparam int byte_width    = 8;
   localparam int bit_idx_width = $clog2(byte_width);

   typedef logic [byte_width-1:0]    byte_t;
   typedef logic [bit_idx_width-1:0] bit_idx_t;   // bit position within a byte

   // sck is high only in tx_sck_hi
   typedef enum logic [1:0] {
      tx_idle   = 2'd0,
      tx_sck_lo = 2'd1,
      tx_sck_hi = 2'd2
   } tx_state_e;

endpackage

//--- src/max7219_pkg.sv
package max7219_pkg;

   typedef logic [7:0] reg_addr_t;

   // register map from the datasheet
   localparam reg_addr_t reg_noop         = 8'h00;
   localparam reg_addr_t reg_digit0       = 8'h01;
   localparam reg_addr_t reg_decode_mode  = 8'h09;
   localparam reg_addr_t reg_intensity    = 8'h0A;
   localparam reg_addr_t reg_scan_limit   = 8'h0B;
   localparam reg_addr_t reg_shutdown     = 8'h0C;
   localparam reg_addr_t reg_display_test = 8'h0F;

   // one 16-bit frame built as fields and shifted out as bytes
   typedef union packed {
      struct packed {
         reg_addr_t  addr;
         logic [7:0] value;
      } fields;
      spi_pkg::byte_t [1:0] bytes;   // bytes[1] goes out first
   } max_frame_u;

   localparam int num_setup_frames = 6;

   localparam max_frame_u setup_frames [0:num_setup_frames-1] = '{
      max_frame_u'({reg_noop,         8'h00}),   // flushes a half-shifted word
      max_frame_u'({reg_display_test, 8'h00}),
      max_frame_u'({reg_scan_limit,   8'h07}),   // all eight digits
      max_frame_u'({reg_decode_mode,  8'h00}),   // raw segments
      max_frame_u'({reg_shutdown,     8'h01}),   // normal operation
      max_frame_u'({reg_intensity,    8'h07})
   };

   localparam int num_digits = 8;

   typedef logic [2:0] digit_idx_t;
   typedef logic [7:0] seg_code_t;   // dp in bit 7 and a..g in 6..0

   // hex glyphs with dp off
   localparam seg_code_t seg_table [0:15] = '{
      8'h7E, 8'h30, 8'h6D, 8'h79,
      8'h33, 8'h5B, 8'h5F, 8'h70,
      8'h7F, 8'h7B, 8'h77, 8'h1F,
      8'h4E, 8'h3D, 8'h4F, 8'h47
   };

endpackage

//--- src/spi_byte_tx.sv
`timescale 1ns/1ps

module spi_byte_tx #(
   parameter int clk_div = 10
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           tx_start,
   input  spi_pkg::byte_t tx_byte,
   output logic           tx_done,
   output logic           din,
   output logic           sck
);

   localparam int cnt_w = (clk_div > 1) ? $clog2(clk_div) : 1;
   localparam logic [cnt_w-1:0] half_last = cnt_w'(clk_div - 1);
   localparam spi_pkg::bit_idx_t msb_idx = spi_pkg::bit_idx_t'(spi_pkg::byte_width - 1);

   spi_pkg::tx_state_e state;
   logic [cnt_w-1:0]   half_cnt;   // cycles spent in the current phase
   spi_pkg::bit_idx_t  bit_idx;    // bit now on din
   spi_pkg::byte_t     shift_byte;

   // device samples on the rising edge
   assign sck = (state == spi_pkg::tx_sck_hi);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= spi_pkg::tx_idle;
         half_cnt <= '0;
         bit_idx  <= '0;
         din      <= 1'b0;
         tx_done  <= 1'b0;
      end else begin
         tx_done <= 1'b0;
         case (state)
            spi_pkg::tx_idle: begin
               half_cnt <= '0;
               if (tx_start) begin
                  bit_idx <= msb_idx;
                  din     <= tx_byte[msb_idx];   // msb ready before first rise
                  state   <= spi_pkg::tx_sck_lo;
               end
            end
            spi_pkg::tx_sck_lo: begin
               if (half_cnt == half_last) begin
                  half_cnt <= '0;
                  state    <= spi_pkg::tx_sck_hi;
               end else begin
                  half_cnt <= half_cnt + 1'b1;
               end
            end
            spi_pkg::tx_sck_hi: begin
               if (half_cnt == half_last) begin
                  half_cnt <= '0;
                  if (bit_idx == '0) begin
                     state   <= spi_pkg::tx_idle;
                     tx_done <= 1'b1;   // last high phase over
                     din     <= 1'b0;
                  end else begin
                     bit_idx <= bit_idx - 1'b1;
                     din     <= shift_byte[bit_idx - 1'b1];   // next bit at start of low
                     state   <= spi_pkg::tx_sck_lo;
                  end
               end else begin
                  half_cnt <= half_cnt + 1'b1;
               end
            end
            default: state <= spi_pkg::tx_idle;
         endcase
      end
   end

   // byte held for the whole transfer
   always_ff @(posedge clk) begin
      if (state == spi_pkg::tx_idle && tx_start) begin
         shift_byte <= tx_byte;
      end
   end

endmodule

//--- src/digit_scanner.sv
`timescale 1ns/1ps

module digit_scanner (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   digit_next,
   input  logic [31:0]            display_value,
   output max7219_pkg::reg_addr_t digit_addr,
   output max7219_pkg::seg_code_t digit_seg
);

   localparam max7219_pkg::digit_idx_t last_digit =
      max7219_pkg::digit_idx_t'(max7219_pkg::num_digits - 1);

   max7219_pkg::digit_idx_t digit_idx;   // 0 is digit 1
   logic [31:0]             value_sr;    // low nibble is the current digit
   logic                    reload_pend;
   logic                    wrap;
   logic [3:0]              nibble;

   assign wrap = digit_next && (digit_idx == last_digit);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         digit_idx   <= '0;
         reload_pend <= 1'b1;   // first scan value taken right after reset
      end else begin
         reload_pend <= 1'b0;
         if (digit_next) begin
            if (wrap) begin
               digit_idx <= '0;
            end else begin
               digit_idx <= digit_idx + 1'b1;
            end
         end
      end
   end

   // new value only at the start of a scan
   always_ff @(posedge clk) begin
      if (reload_pend || wrap) begin
         value_sr <= display_value;
      end else if (digit_next) begin
         value_sr <= {4'h0, value_sr[31:4]};
      end
   end

   // until the first load the input itself is shown
   assign nibble = reload_pend ? display_value[3:0] : value_sr[3:0];

   assign digit_addr = max7219_pkg::reg_digit0 + max7219_pkg::reg_addr_t'(digit_idx);
   assign digit_seg  = max7219_pkg::seg_table[nibble];

endmodule

//--- src/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer #(
   parameter int clk_div = 10
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  max7219_pkg::reg_addr_t digit_addr,
   input  max7219_pkg::seg_code_t digit_seg,
   input  logic                   tx_done,
   output logic                   tx_start,
   output spi_pkg::byte_t         tx_byte,
   output logic                   digit_next,
   output logic                   load
);

   localparam int cnt_w = (clk_div > 1) ? $clog2(clk_div) : 1;
   localparam logic [cnt_w-1:0] load_last = cnt_w'(clk_div - 1);
   localparam int ptr_w = $clog2(max7219_pkg::num_setup_frames);
   localparam logic [ptr_w-1:0] ptr_last = ptr_w'(max7219_pkg::num_setup_frames - 1);

   // frame phases
   localparam logic [2:0] s_send_hi = 3'd0;
   localparam logic [2:0] s_wait_hi = 3'd1;
   localparam logic [2:0] s_send_lo = 3'd2;
   localparam logic [2:0] s_wait_lo = 3'd3;
   localparam logic [2:0] s_load    = 3'd4;

   logic [2:0]              state;
   logic [cnt_w-1:0]        load_cnt;
   logic [ptr_w-1:0]        setup_ptr;
   logic                    setup_done;   // sticky until reset
   logic                    load_end;
   max7219_pkg::max_frame_u frame;

   always_comb begin
      if (setup_done) begin
         frame.fields.addr  = digit_addr;
         frame.fields.value = digit_seg;
      end else begin
         frame = max7219_pkg::setup_frames[setup_ptr];
      end
   end

   assign tx_start = (state == s_send_hi) || (state == s_send_lo);
   assign tx_byte  = (state == s_send_hi) ? frame.bytes[1] : frame.bytes[0];
   assign load     = (state == s_load);
   assign load_end = load && (load_cnt == load_last);

   // scanner steps as load falls so the next frame sees the new digit
   assign digit_next = load_end && setup_done;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= s_send_hi;
         load_cnt   <= '0;
         setup_ptr  <= '0;
         setup_done <= 1'b0;
      end else begin
         case (state)
            s_send_hi: state <= s_wait_hi;
            s_wait_hi: if (tx_done) state <= s_send_lo;
            s_send_lo: state <= s_wait_lo;
            s_wait_lo: begin
               if (tx_done) begin
                  load_cnt <= '0;
                  state    <= s_load;
               end
            end
            s_load: begin
               if (load_end) begin
                  state <= s_send_hi;   // back to back frames
                  if (!setup_done) begin
                     if (setup_ptr == ptr_last) begin
                        setup_done <= 1'b1;
                     end else begin
                        setup_ptr <= setup_ptr + 1'b1;
                     end
                  end
               end else begin
                  load_cnt <= load_cnt + 1'b1;
               end
            end
            default: state <= s_send_hi;
         endcase
      end
   end

endmodule

//--- src/max7219_display.sv
`timescale 1ns/1ps

module max7219_display #(
   parameter int clk_div = 10   // clk cycles per sck half period
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [31:0] display_value,
   output logic        din,
   output logic        sck,
   output logic        load
);

   logic                   tx_start;
   spi_pkg::byte_t         tx_byte;
   logic                   tx_done;
   logic                   digit_next;
   max7219_pkg::reg_addr_t digit_addr;
   max7219_pkg::seg_code_t digit_seg;

   frame_sequencer #(.clk_div(clk_div)) i_sequencer (
      .clk        (clk),
      .rst_n      (rst_n),
      .digit_addr (digit_addr),
      .digit_seg  (digit_seg),
      .tx_done    (tx_done),
      .tx_start   (tx_start),
      .tx_byte    (tx_byte),
      .digit_next (digit_next),
      .load       (load)
   );

   digit_scanner i_scanner (
      .clk           (clk),
      .rst_n         (rst_n),
      .digit_next    (digit_next),
      .display_value (display_value),
      .digit_addr    (digit_addr),
      .digit_seg     (digit_seg)
   );

   spi_byte_tx #(.clk_div(clk_div)) i_spi_tx (
      .clk      (clk),
      .rst_n    (rst_n),
      .tx_start (tx_start),
      .tx_byte  (tx_byte),
      .tx_done  (tx_done),
      .din      (din),
      .sck      (sck)
   );

endmodule

//--- dv/max7219_capture.sv
`timescale 1ns/1ps

module max7219_capture (
   input  logic                    rst_n,
   input  logic                    din,
   input  logic                    sck,
   input  logic                    load,
   output max7219_pkg::max_frame_u frame,
   output int                      bits,
   output logic                    sck_at_load,
   output int                      count
);

   logic [15:0] shreg = '0;
   int          rises = 0;   // sck rises since time zero
   int          base  = 0;   // rises at the last load or reset

   // chip takes din on the rising edge of sck
   always @(posedge sck) begin
      shreg <= {shreg[14:0], din};
      rises <= rises + 1;
   end

   // load rise latches the last 16 bits
   always @(posedge load or negedge rst_n) begin
      if (!rst_n) begin
         frame       <= '0;
         bits        <= 0;
         sck_at_load <= 1'b0;
         count       <= 0;
         base        <= rises;   // aborted frame not counted
      end else begin
         frame       <= shreg;
         bits        <= rises - base;
         sck_at_load <= sck;
         count       <= count + 1;
         base        <= rises;
      end
   end

endmodule

//--- dv/tb_max7219_display.sv
`timescale 1ns/1ps

module tb_max7219_display;

   localparam int num_values = 8;
   localparam int wait_limit = 2000;   // cycles per frame wait

   logic                    clk;
   logic                    rst_n;
   logic [31:0]             display_value;
   logic                    din;
   logic                    sck;
   logic                    load;
   max7219_pkg::max_frame_u cap_frame;
   int                      cap_bits;
   logic                    cap_sck_at_load;
   int                      cap_count;
   int                      errors   = 0;
   int                      checks   = 0;
   int                      timeouts = 0;
   integer                  seed     = 3;
   logic [31:0]             values [0:num_values-1];

   // hex glyphs 0..F with dp off
   max7219_pkg::seg_code_t seg_ref [0:15] = '{
      8'h7E, 8'h30, 8'h6D, 8'h79, 8'h33, 8'h5B, 8'h5F, 8'h70,
      8'h7F, 8'h7B, 8'h77, 8'h1F, 8'h4E, 8'h3D, 8'h4F, 8'h47
   };

   max7219_display #(.clk_div(2)) i_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .display_value (display_value),
      .din           (din),
      .sck           (sck),
      .load          (load)
   );

   max7219_capture i_capture (
      .rst_n       (rst_n),
      .din         (din),
      .sck         (sck),
      .load        (load),
      .frame       (cap_frame),
      .bits        (cap_bits),
      .sck_at_load (cap_sck_at_load),
      .count       (cap_count)
   );

   always #20 clk = ~clk;

   function automatic max7219_pkg::max_frame_u make_frame(
      input max7219_pkg::reg_addr_t addr, input logic [7:0] value);
      max7219_pkg::max_frame_u f;
      f.fields.addr  = addr;
      f.fields.value = value;
      return f;
   endfunction

   // power-up order of the chip setup
   function automatic max7219_pkg::max_frame_u setup_ref(input int n);
      case (n)
         0: return make_frame(max7219_pkg::reg_noop, 8'h00);
         1: return make_frame(max7219_pkg::reg_display_test, 8'h00);
         2: return make_frame(max7219_pkg::reg_scan_limit, 8'h07);
         3: return make_frame(max7219_pkg::reg_decode_mode, 8'h00);
         4: return make_frame(max7219_pkg::reg_shutdown, 8'h01);
         default: return make_frame(max7219_pkg::reg_intensity, 8'h07);
      endcase
   endfunction

   task automatic check_frame(input max7219_pkg::max_frame_u got,
                              input max7219_pkg::max_frame_u exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: %s frame %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bits(input int got, input int exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: %s frame has %0d sck rises, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_level(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic wait_frame(output max7219_pkg::max_frame_u f, output int n);
      int start;
      int cyc;
      start = cap_count;
      cyc   = 0;
      while (cap_count == start && cyc < wait_limit) begin
         @(negedge clk);
         cyc++;
      end
      if (cap_count == start) begin
         timeouts++;
         $display("no load pulse seen within %0d cycles at %0t", wait_limit, $time);
      end
      f = cap_frame;
      n = cap_bits;
      check_level(cap_sck_at_load, 1'b0, "sck at load rise");
   endtask

   task automatic check_setup();
      max7219_pkg::max_frame_u f;
      int n;
      int i;
      for (i = 0; i < max7219_pkg::num_setup_frames; i++) begin
         wait_frame(f, n);
         check_frame(f, setup_ref(i), "setup");
         check_bits(n, 16, "setup");
      end
   endtask

   // one full scan with the input changed after digit 3
   task automatic check_scan(input logic [31:0] value, input logic [31:0] next);
      max7219_pkg::max_frame_u f;
      max7219_pkg::max_frame_u exp;
      int n;
      int k;
      for (k = 1; k <= max7219_pkg::num_digits; k++) begin
         wait_frame(f, n);
         exp = make_frame(max7219_pkg::reg_addr_t'(k), seg_ref[value[4*(k-1) +: 4]]);
         check_frame(f, exp, "digit");
         check_bits(n, 16, "digit");
         if (k == 3) begin
            @(posedge clk);
            #1 display_value = next;
         end
      end
   endtask

   task automatic reset_mid_frame(input logic [31:0] value);
      int i;
      repeat (20) @(posedge clk);   // well into the next frame
      #1 rst_n = 1'b0;
      display_value = value;
      for (i = 0; i < 2; i++) begin
         @(negedge clk);
         check_level(load, 1'b0, "load in reset");
         check_level(sck, 1'b0, "sck in reset");
         check_level(din, 1'b0, "din in reset");
      end
      @(posedge clk);
      #1 rst_n = 1'b1;
   endtask

   initial begin
      int i;
      clk       = 1'b0;
      rst_n     = 1'b1;
      values[0] = 32'h7654_3210;
      values[1] = 32'hFEDC_BA98;
      values[2] = 32'h0000_0000;
      values[3] = 32'hA5A5_5A5A;
      for (i = 4; i < num_values; i++) begin
         values[i] = $random(seed);
      end
      display_value = values[0];
      #1 rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      check_setup();
      for (i = 0; i < num_values; i++) begin
         check_scan(values[i], values[(i + 1) % num_values]);
      end
      reset_mid_frame(32'h1357_9BDF);
      check_setup();
      check_scan(32'h1357_9BDF, 32'h1357_9BDF);
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- build.f
src/spi_pkg.sv
src/max7219_pkg.sv
src/spi_byte_tx.sv
src/digit_scanner.sv
src/frame_sequencer.sv
src/max7219_display.sv
dv/max7219_capture.sv
dv/tb_max7219_display.sv

//--- Makefile
# Verilator flow for the MAX7219 display driver

VERILATOR ?= verilator
TOP       ?= tb_max7219_display
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_MSG)"; then \
	   echo "simulation passed"; \
	else \
	   echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
